// ==== verilog/snoop_fi_config.svh ====
`ifndef SNOOP_FI_CONFIG_SVH
`define SNOOP_FI_CONFIG_SVH

// ------------------------------
// ACE snoop channel widths
// ------------------------------
`define FI_ADDR_W       44
`define FI_DATA_W       128
`define FI_BEATS        4
`define FI_LINE_W       (`FI_BEATS * `FI_DATA_W)
`define FI_CRRESP_W     5

// Register file width
`define FI_REG_W        32

// Base cycle count for the delayed test modes
`define FI_DELAY_BASE   4

// ------------------------------
// Control register layout
// ------------------------------
`define FI_BIT_EN       0
`define FI_TEST_LSB     1
`define FI_FUNC_LSB     5
`define FI_CRRESP_LSB   9
`define FI_BIT_ACFLT    14
`define FI_BIT_ADDRFLT  15
`define FI_BIT_OSH_EN   16
`define FI_BIT_CON_EN   17
`define FI_BIT_PDT_EN   20

`endif

// ==== verilog/snoop_fi_pkg.sv ====
package snoop_fi_pkg;

    // Response sequencer states
    typedef enum logic [4:0]
    {
        ST_IDLE        = 5'd0,
        ST_FILTER      = 5'd1,
        ST_FUNCTION    = 5'd2,
        ST_ONE_SHOT    = 5'd3,
        ST_CONTINUOUS  = 5'd4,
        ST_RESPONSE    = 5'd5,
        ST_DELAY       = 5'd6,
        ST_SNOOP_RESP  = 5'd7,
        ST_REPLY_BURST = 5'd8,
        ST_DUMMY_REPLY = 5'd9,
        ST_END_OP      = 5'd10,
        ST_END_REPLY   = 5'd11
    } fi_state_e;

    // Function field of the control register
    typedef enum logic [3:0]
    {
        FUNC_OSH = 4'd0,
        FUNC_CON = 4'd1,
        FUNC_ADL = 4'd2,
        FUNC_ADT = 4'd3,
        FUNC_PDT = 4'd4
    } fi_func_e;

    // Fault injection test modes
    typedef enum logic [3:0]
    {
        TEST_NORMAL        = 4'd0,
        TEST_FUZZING       = 4'd1,
        TEST_DELAY_CRVALID = 4'd2,
        TEST_DELAY_CDVALID = 4'd3,
        TEST_DELAY_CDLAST  = 4'd4
    } fi_test_e;

endpackage

// ==== verilog/snoop_ctrl_if.sv ====
`include "snoop_fi_config.svh"

interface snoop_ctrl_if;

    logic                         enable;
    snoop_fi_pkg::fi_func_e       func;
    snoop_fi_pkg::fi_test_e       test;
    logic [`FI_CRRESP_W-1:0]      crresp;
    logic                         osh_en;
    logic                         con_en;
    logic                         pdt_en;
    // Combined opcode and address window verdict
    logic                         pass;

    modport decode (output enable, func, test, crresp, osh_en, con_en, pdt_en, pass);

    modport execute (input enable, func, test, crresp, osh_en, con_en, pdt_en, pass);

endinterface

// ==== verilog/snoop_resp_if.sv ====
`include "snoop_fi_config.svh"

interface snoop_resp_if;

    // Single cycle commands toward the CR/CD registers
    logic                         set_cr;
    logic [`FI_CRRESP_W-1:0]      resp_code;
    logic                         set_cd;
    logic                         set_last;
    logic                         start_burst;
    logic                         clear_all;
    logic                         dummy;

    // High once the last CD beat has been taken
    logic                         burst_done;

    modport execute (output set_cr, resp_code, set_cd, set_last, start_burst,
                     clear_all, dummy, input burst_done);

    modport result (input set_cr, resp_code, set_cd, set_last, start_burst,
                    clear_all, dummy, output burst_done);

endinterface

// ==== verilog/snoop_ctrl_decode.sv ====
`include "snoop_fi_config.svh"

module snoop_ctrl_decode
(
    input  logic [`FI_REG_W-1:0]   i_control_reg,
    input  logic [`FI_REG_W-1:0]   i_acsnoop_reg,
    input  logic [`FI_REG_W-1:0]   i_base_addr_reg,
    input  logic [`FI_REG_W-1:0]   i_addr_size_reg,
    input  logic [`FI_ADDR_W-1:0]  i_acaddr_snapshot,
    input  logic [3:0]             i_acsnoop_snapshot,
    snoop_ctrl_if.decode           ctrl
);

    logic        ac_match;
    logic        addr_match;
    logic        ac_flt_en;
    logic        addr_flt_en;
    logic [31:0] win_addr;
    logic [31:0] win_end;

    // ------------------------------
    // Control register fields
    // ------------------------------
    assign ctrl.enable = i_control_reg[`FI_BIT_EN];
    assign ctrl.test   = snoop_fi_pkg::fi_test_e'(
                         i_control_reg[`FI_TEST_LSB +: $bits(snoop_fi_pkg::fi_test_e)]);
    assign ctrl.func   = snoop_fi_pkg::fi_func_e'(
                         i_control_reg[`FI_FUNC_LSB +: $bits(snoop_fi_pkg::fi_func_e)]);
    assign ctrl.crresp = i_control_reg[`FI_CRRESP_LSB +: `FI_CRRESP_W];
    assign ctrl.osh_en = i_control_reg[`FI_BIT_OSH_EN];
    assign ctrl.con_en = i_control_reg[`FI_BIT_CON_EN];
    assign ctrl.pdt_en = i_control_reg[`FI_BIT_PDT_EN];

    assign ac_flt_en   = i_control_reg[`FI_BIT_ACFLT];
    assign addr_flt_en = i_control_reg[`FI_BIT_ADDRFLT];

    // ------------------------------
    // Snapshot filters
    // ------------------------------
    assign ac_match = (i_acsnoop_snapshot == i_acsnoop_reg[3:0]);

    // Window compare on the low 32 address bits only
    assign win_addr   = i_acaddr_snapshot[31:0];
    assign win_end    = i_base_addr_reg[31:0] + i_addr_size_reg[31:0];
    assign addr_match = (win_addr >= i_base_addr_reg[31:0]) && (win_addr < win_end);

    // A disabled filter always passes
    assign ctrl.pass = (!ac_flt_en || ac_match) && (!addr_flt_en || addr_match);

endmodule

// ==== verilog/snoop_fault_fsm.sv ====
`include "snoop_fi_config.svh"

module snoop_fault_fsm
(
    input  logic                   ace_aclk,
    input  logic                   ace_aresetn,
    input  logic                   i_trigger,
    input  logic                   i_crready,
    input  logic [`FI_REG_W-1:0]   i_delay_reg,
    snoop_ctrl_if.execute          ctrl,
    snoop_resp_if.execute          resp,
    output logic                   o_reply,
    output logic                   o_end,
    output logic                   o_busy
);

    snoop_fi_pkg::fi_state_e state;
    snoop_fi_pkg::fi_state_e ret_state;
    logic [`FI_REG_W-1:0]    delay_cnt;
    logic [`FI_REG_W-1:0]    delay_target;
    logic                    delay_hit;
    logic                    delayed_mode;
    logic                    osh_done;
    logic                    burst_run;

    // Base cycles doubled for each delay step above one
    assign delay_target = (i_delay_reg == '0) ? '0 :
                          (`FI_REG_W'(`FI_DELAY_BASE) << (i_delay_reg - 1'b1));
    assign delay_hit    = (delay_cnt == delay_target);

    assign delayed_mode = (ctrl.test == snoop_fi_pkg::TEST_DELAY_CRVALID) ||
                          (ctrl.test == snoop_fi_pkg::TEST_DELAY_CDVALID) ||
                          (ctrl.test == snoop_fi_pkg::TEST_DELAY_CDLAST);

    assign o_busy = (state != snoop_fi_pkg::ST_IDLE);

    // ------------------------------
    // State sequencing
    // ------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            state     <= snoop_fi_pkg::ST_IDLE;
            ret_state <= snoop_fi_pkg::ST_END_REPLY;
            delay_cnt <= '0;
            osh_done  <= 1'b0;
            burst_run <= 1'b0;
            o_reply   <= 1'b0;
            o_end     <= 1'b0;
        end
        else
        begin
            o_reply <= 1'b0;
            case (state)
                snoop_fi_pkg::ST_IDLE:
                begin
                    // Disabling the block re-arms the one-shot
                    if (!ctrl.enable)
                    begin
                        osh_done <= 1'b0;
                        o_end    <= 1'b0;
                    end
                    if (i_trigger)
                        state <= snoop_fi_pkg::ST_FILTER;
                end
                snoop_fi_pkg::ST_FILTER:
                begin
                    if (ctrl.pass)
                        state <= snoop_fi_pkg::ST_FUNCTION;
                    else
                        state <= snoop_fi_pkg::ST_DUMMY_REPLY;
                end
                snoop_fi_pkg::ST_FUNCTION:
                begin
                    case (ctrl.func)
                        snoop_fi_pkg::FUNC_OSH:
                            state <= (ctrl.osh_en && !osh_done) ? snoop_fi_pkg::ST_ONE_SHOT
                                                                : snoop_fi_pkg::ST_DUMMY_REPLY;
                        snoop_fi_pkg::FUNC_CON:
                            state <= ctrl.con_en ? snoop_fi_pkg::ST_CONTINUOUS
                                                 : snoop_fi_pkg::ST_DUMMY_REPLY;
                        snoop_fi_pkg::FUNC_PDT:
                            state <= ctrl.pdt_en ? snoop_fi_pkg::ST_SNOOP_RESP
                                                 : snoop_fi_pkg::ST_DUMMY_REPLY;
                        // Leak and tamper belong to the active side
                        snoop_fi_pkg::FUNC_ADL,
                        snoop_fi_pkg::FUNC_ADT:
                            state <= snoop_fi_pkg::ST_DUMMY_REPLY;
                        default:
                            state <= snoop_fi_pkg::ST_DUMMY_REPLY;
                    endcase
                end
                snoop_fi_pkg::ST_ONE_SHOT:
                begin
                    if (i_crready)
                    begin
                        osh_done  <= 1'b1;
                        ret_state <= snoop_fi_pkg::ST_END_OP;
                        state     <= snoop_fi_pkg::ST_RESPONSE;
                    end
                end
                snoop_fi_pkg::ST_CONTINUOUS:
                begin
                    if (i_crready)
                    begin
                        ret_state <= snoop_fi_pkg::ST_END_REPLY;
                        state     <= snoop_fi_pkg::ST_RESPONSE;
                    end
                end
                snoop_fi_pkg::ST_RESPONSE:
                    state <= delayed_mode ? snoop_fi_pkg::ST_DELAY : ret_state;
                snoop_fi_pkg::ST_DELAY:
                begin
                    if (delay_hit)
                    begin
                        delay_cnt <= '0;
                        state     <= ret_state;
                    end
                    else
                        delay_cnt <= delay_cnt + 1'b1;
                end
                snoop_fi_pkg::ST_SNOOP_RESP:
                begin
                    if (i_crready)
                        state <= snoop_fi_pkg::ST_REPLY_BURST;
                end
                snoop_fi_pkg::ST_REPLY_BURST:
                begin
                    burst_run <= 1'b1;
                    if (burst_run && resp.burst_done)
                    begin
                        burst_run <= 1'b0;
                        state     <= snoop_fi_pkg::ST_END_REPLY;
                    end
                end
                snoop_fi_pkg::ST_DUMMY_REPLY:
                begin
                    if (i_crready)
                        state <= snoop_fi_pkg::ST_END_REPLY;
                end
                snoop_fi_pkg::ST_END_OP:
                begin
                    o_end   <= 1'b1;
                    o_reply <= 1'b1;
                    state   <= snoop_fi_pkg::ST_IDLE;
                end
                snoop_fi_pkg::ST_END_REPLY:
                begin
                    o_reply <= 1'b1;
                    state   <= snoop_fi_pkg::ST_IDLE;
                end
                default:
                    state <= snoop_fi_pkg::ST_IDLE;
            endcase
        end
    end

    // ------------------------------
    // Driver commands
    // ------------------------------
    always_comb
    begin
        resp.set_cr      = 1'b0;
        resp.resp_code   = ctrl.crresp;
        resp.set_cd      = 1'b0;
        resp.set_last    = 1'b0;
        resp.start_burst = 1'b0;
        resp.clear_all   = 1'b0;
        resp.dummy       = 1'b0;
        case (state)
            snoop_fi_pkg::ST_RESPONSE:
            begin
                // Delayed modes hold back one signal until DELAY expires
                case (ctrl.test)
                    snoop_fi_pkg::TEST_FUZZING:
                    begin
                        resp.set_cr   = 1'b1;
                        resp.set_cd   = 1'b1;
                        resp.set_last = 1'b1;
                    end
                    snoop_fi_pkg::TEST_DELAY_CRVALID:
                    begin
                        resp.set_cd   = 1'b1;
                        resp.set_last = 1'b1;
                    end
                    snoop_fi_pkg::TEST_DELAY_CDVALID:
                    begin
                        resp.set_cr   = 1'b1;
                        resp.set_last = 1'b1;
                    end
                    snoop_fi_pkg::TEST_DELAY_CDLAST:
                    begin
                        resp.set_cr   = 1'b1;
                        resp.set_cd   = 1'b1;
                    end
                    default:
                        resp.set_cr   = 1'b1;
                endcase
            end
            snoop_fi_pkg::ST_DELAY:
            begin
                resp.set_cr   = delay_hit && (ctrl.test == snoop_fi_pkg::TEST_DELAY_CRVALID);
                resp.set_cd   = delay_hit && (ctrl.test == snoop_fi_pkg::TEST_DELAY_CDVALID);
                resp.set_last = delay_hit && (ctrl.test == snoop_fi_pkg::TEST_DELAY_CDLAST);
            end
            snoop_fi_pkg::ST_SNOOP_RESP:
                resp.set_cr = i_crready;
            snoop_fi_pkg::ST_REPLY_BURST:
                resp.start_burst = !burst_run;
            snoop_fi_pkg::ST_DUMMY_REPLY:
                resp.dummy = i_crready;
            snoop_fi_pkg::ST_END_OP,
            snoop_fi_pkg::ST_END_REPLY:
                resp.clear_all = 1'b1;
            default:
            begin
                resp.clear_all = 1'b0;
            end
        endcase
    end

    // Every return to idle comes with the reply pulse
    a_reply_on_exit: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        $fell(o_busy) |-> o_reply);

endmodule

// ==== verilog/snoop_resp_driver.sv ====
`include "snoop_fi_config.svh"

module snoop_resp_driver
(
    input  logic                     ace_aclk,
    input  logic                     ace_aresetn,
    input  logic                     i_cdready,
    input  logic [`FI_LINE_W-1:0]    i_cache_line,
    snoop_resp_if.result             resp,
    output logic [`FI_CRRESP_W-1:0]  o_crresp,
    output logic                     o_crvalid,
    output logic [`FI_DATA_W-1:0]    o_cddata,
    output logic                     o_cdvalid,
    output logic                     o_cdlast
);

    localparam int                BEAT_W    = $clog2(`FI_BEATS);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`FI_BEATS - 1);

    logic [BEAT_W-1:0] beat_cnt;
    logic [BEAT_W-1:0] beat_next;
    logic              bursting;
    logic              beat_acc;

    assign beat_next = beat_cnt + 1'b1;
    assign beat_acc  = bursting && o_cdvalid && i_cdready;

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn || resp.clear_all)
        begin
            o_crresp        <= '0;
            o_crvalid       <= 1'b0;
            o_cddata        <= '0;
            o_cdvalid       <= 1'b0;
            o_cdlast        <= 1'b0;
            beat_cnt        <= '0;
            bursting        <= 1'b0;
            resp.burst_done <= 1'b0;
        end
        else if (resp.start_burst)
        begin
            // CR handshake is over, first line slice goes out
            o_crresp        <= '0;
            o_crvalid       <= 1'b0;
            o_cddata        <= i_cache_line[0 +: `FI_DATA_W];
            o_cdvalid       <= 1'b1;
            o_cdlast        <= 1'b0;
            beat_cnt        <= '0;
            bursting        <= 1'b1;
            resp.burst_done <= 1'b0;
        end
        else if (beat_acc)
        begin
            if (beat_cnt == LAST_BEAT)
            begin
                o_cdvalid       <= 1'b0;
                o_cdlast        <= 1'b0;
                bursting        <= 1'b0;
                resp.burst_done <= 1'b1;
            end
            else
            begin
                beat_cnt <= beat_next;
                o_cddata <= i_cache_line[beat_next * `FI_DATA_W +: `FI_DATA_W];
                o_cdlast <= (beat_next == LAST_BEAT);
            end
        end
        else if (resp.dummy)
        begin
            o_crresp  <= '0;
            o_cddata  <= '0;
            o_crvalid <= 1'b1;
        end
        else
        begin
            if (resp.set_cr)
            begin
                o_crvalid <= 1'b1;
                o_crresp  <= resp.resp_code;
            end
            if (resp.set_cd)
                o_cdvalid <= 1'b1;
            if (resp.set_last)
                o_cdlast <= 1'b1;
        end
    end

    // Stalled beat keeps its data
    a_cddata_hold: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        (bursting && o_cdvalid && !i_cdready) |=> $stable(o_cddata));

    // Last flag only on the final valid beat of a burst
    a_cdlast_final: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        (bursting && o_cdlast) |-> (o_cdvalid && beat_cnt == LAST_BEAT));

endmodule

// ==== verilog/snoop_fault_top.sv ====
`include "snoop_fi_config.svh"

module snoop_fault_top
(
    input  logic                     ace_aclk,
    input  logic                     ace_aresetn,
    input  logic                     i_trigger,
    input  logic [`FI_ADDR_W-1:0]    i_acaddr_snapshot,
    input  logic [3:0]               i_acsnoop_snapshot,
    input  logic [`FI_REG_W-1:0]     i_control_reg,
    input  logic [`FI_REG_W-1:0]     i_delay_reg,
    input  logic [`FI_REG_W-1:0]     i_acsnoop_reg,
    input  logic [`FI_REG_W-1:0]     i_base_addr_reg,
    input  logic [`FI_REG_W-1:0]     i_addr_size_reg,
    input  logic [`FI_LINE_W-1:0]    i_cache_line,
    input  logic                     i_crready,
    input  logic                     i_cdready,
    output logic [`FI_CRRESP_W-1:0]  o_crresp,
    output logic                     o_crvalid,
    output logic [`FI_DATA_W-1:0]    o_cddata,
    output logic                     o_cdvalid,
    output logic                     o_cdlast,
    output logic                     o_reply,
    output logic                     o_end,
    output logic                     o_busy
);

    snoop_ctrl_if ctrl_bus ();
    snoop_resp_if resp_bus ();

    // Register split and filters
    snoop_ctrl_decode u_decode
    (
        .i_control_reg      (i_control_reg),
        .i_acsnoop_reg      (i_acsnoop_reg),
        .i_base_addr_reg    (i_base_addr_reg),
        .i_addr_size_reg    (i_addr_size_reg),
        .i_acaddr_snapshot  (i_acaddr_snapshot),
        .i_acsnoop_snapshot (i_acsnoop_snapshot),
        .ctrl               (ctrl_bus.decode)
    );

    // Response sequencing
    snoop_fault_fsm u_fsm
    (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_trigger   (i_trigger),
        .i_crready   (i_crready),
        .i_delay_reg (i_delay_reg),
        .ctrl        (ctrl_bus.execute),
        .resp        (resp_bus.execute),
        .o_reply     (o_reply),
        .o_end       (o_end),
        .o_busy      (o_busy)
    );

    // CR and CD channel registers
    snoop_resp_driver u_driver
    (
        .ace_aclk     (ace_aclk),
        .ace_aresetn  (ace_aresetn),
        .i_cdready    (i_cdready),
        .i_cache_line (i_cache_line),
        .resp         (resp_bus.result),
        .o_crresp     (o_crresp),
        .o_crvalid    (o_crvalid),
        .o_cddata     (o_cddata),
        .o_cdvalid    (o_cdvalid),
        .o_cdlast     (o_cdlast)
    );

endmodule

// ==== bench/tb_snoop_vectors.svh ====
`ifndef TB_SNOOP_VECTORS_SVH
`define TB_SNOOP_VECTORS_SVH

// Columns: func, test, crresp, ac filter, addr filter, delay, snoop op, snoop reg,
// addr, window base, window size, cr hold, cd hold, random cd stall, enable-off cycle,
// expected code, expected beats, o_end at reply, minimum CR latency
typedef struct packed
{
    snoop_fi_pkg::fi_func_e    func;
    snoop_fi_pkg::fi_test_e    test;
    logic [`FI_CRRESP_W-1:0]   crresp;
    logic                      acflt;
    logic                      addrflt;
    logic [3:0]                delay;
    logic [3:0]                snoop;
    logic [3:0]                snoop_reg;
    logic [31:0]               addr;
    logic [31:0]               base;
    logic [31:0]               size;
    logic [7:0]                cr_hold;
    logic [7:0]                cd_hold;
    logic                      cd_rand;
    logic                      idle_off;
    logic [`FI_CRRESP_W-1:0]   exp_code;
    logic [3:0]                exp_beats;
    logic                      exp_end;
    logic [7:0]                exp_min;
} vec_t;

localparam int NUM_VEC = 11;

vec_t vec_tab [NUM_VEC] = '{
    // Opcode mismatch, then address outside the window
    '{snoop_fi_pkg::FUNC_PDT, snoop_fi_pkg::TEST_NORMAL, 5'h0B, 1'b1, 1'b0, 4'd0, 4'h7, 4'h1,
      32'h4010, 32'h4000, 32'h100, 8'd0, 8'd0, 1'b0, 1'b0, 5'h00, 4'd0, 1'b0, 8'd0},
    '{snoop_fi_pkg::FUNC_PDT, snoop_fi_pkg::TEST_NORMAL, 5'h0B, 1'b0, 1'b1, 4'd0, 4'h1, 4'h1,
      32'h5000, 32'h4000, 32'h100, 8'd0, 8'd0, 1'b0, 1'b0, 5'h00, 4'd0, 1'b0, 8'd0},
    // PDT bursts, one with a random CD stall, one with CR ready held low
    '{snoop_fi_pkg::FUNC_PDT, snoop_fi_pkg::TEST_NORMAL, 5'h0B, 1'b1, 1'b1, 4'd0, 4'h1, 4'h1,
      32'h40F0, 32'h4000, 32'h100, 8'd0, 8'd5, 1'b1, 1'b0, 5'h0B, 4'd4, 1'b0, 8'd0},
    '{snoop_fi_pkg::FUNC_PDT, snoop_fi_pkg::TEST_NORMAL, 5'h13, 1'b0, 1'b0, 4'd0, 4'h2, 4'h1,
      32'h0000, 32'h4000, 32'h100, 8'd8, 8'd0, 1'b0, 1'b0, 5'h13, 4'd4, 1'b0, 8'd0},
    // Continuous with CR valid held back
    '{snoop_fi_pkg::FUNC_CON, snoop_fi_pkg::TEST_DELAY_CRVALID, 5'h05, 1'b0, 1'b0, 4'd1,
      4'h0, 4'h0, 32'h0, 32'h0, 32'h0, 8'd0, 8'hFF, 1'b0, 1'b0, 5'h05, 4'd0, 1'b0, 8'd4},
    '{snoop_fi_pkg::FUNC_CON, snoop_fi_pkg::TEST_DELAY_CRVALID, 5'h06, 1'b0, 1'b0, 4'd2,
      4'h0, 4'h0, 32'h0, 32'h0, 32'h0, 8'd0, 8'hFF, 1'b0, 1'b0, 5'h06, 4'd0, 1'b0, 8'd8},
    '{snoop_fi_pkg::FUNC_CON, snoop_fi_pkg::TEST_NORMAL, 5'h1A, 1'b0, 1'b0, 4'd0,
      4'h0, 4'h0, 32'h0, 32'h0, 32'h0, 8'd12, 8'd0, 1'b0, 1'b0, 5'h1A, 4'd0, 1'b0, 8'd0},
    // Leak code has no passive action
    '{snoop_fi_pkg::FUNC_ADL, snoop_fi_pkg::TEST_FUZZING, 5'h1F, 1'b0, 1'b0, 4'd0,
      4'h0, 4'h0, 32'h0, 32'h0, 32'h0, 8'd0, 8'd0, 1'b0, 1'b0, 5'h00, 4'd0, 1'b0, 8'd0},
    // One-shot fires, is spent, then re-armed
    '{snoop_fi_pkg::FUNC_OSH, snoop_fi_pkg::TEST_FUZZING, 5'h11, 1'b0, 1'b0, 4'd0,
      4'h0, 4'h0, 32'h0, 32'h0, 32'h0, 8'd0, 8'd0, 1'b0, 1'b0, 5'h11, 4'd1, 1'b1, 8'd0},
    '{snoop_fi_pkg::FUNC_OSH, snoop_fi_pkg::TEST_FUZZING, 5'h11, 1'b0, 1'b0, 4'd0,
      4'h0, 4'h0, 32'h0, 32'h0, 32'h0, 8'd0, 8'd0, 1'b0, 1'b0, 5'h00, 4'd0, 1'b1, 8'd0},
    '{snoop_fi_pkg::FUNC_OSH, snoop_fi_pkg::TEST_FUZZING, 5'h11, 1'b0, 1'b0, 4'd0,
      4'h0, 4'h0, 32'h0, 32'h0, 32'h0, 8'd0, 8'd0, 1'b0, 1'b1, 5'h11, 4'd1, 1'b1, 8'd0}
};

`endif

// ==== bench/tb_snoop_fault.sv ====
`include "snoop_fi_config.svh"

module tb_snoop_fault;

    timeunit 1ns;
    timeprecision 1ps;

    logic                     ace_aclk;
    logic                     ace_aresetn;
    logic                     i_trigger;
    logic [`FI_ADDR_W-1:0]    i_acaddr_snapshot;
    logic [3:0]               i_acsnoop_snapshot;
    logic [`FI_REG_W-1:0]     i_control_reg;
    logic [`FI_REG_W-1:0]     i_delay_reg;
    logic [`FI_REG_W-1:0]     i_acsnoop_reg;
    logic [`FI_REG_W-1:0]     i_base_addr_reg;
    logic [`FI_REG_W-1:0]     i_addr_size_reg;
    logic [`FI_LINE_W-1:0]    i_cache_line;
    logic                     i_crready;
    logic                     i_cdready;
    logic [`FI_CRRESP_W-1:0]  o_crresp;
    logic                     o_crvalid;
    logic [`FI_DATA_W-1:0]    o_cddata;
    logic                     o_cdvalid;
    logic                     o_cdlast;
    logic                     o_reply;
    logic                     o_end;
    logic                     o_busy;

    int seed      = 49825;
    int err_cnt   = 0;
    int check_cnt = 0;
    int cycle_cnt = 0;

    `include "tb_snoop_vectors.svh"

    localparam int CYCLE_LIMIT = NUM_VEC * 200;

    snoop_fault_top DUT (.*);

    always #5 ace_aclk = ~ace_aclk;

    // Run limit
    always @(posedge ace_aclk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("Timeout, the DUT did not finish the table within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check(input string name, input logic [`FI_DATA_W-1:0] actual,
                         input logic [`FI_DATA_W-1:0] expected);
        check_cnt++;
        if (actual !== expected)
        begin
            $display("error: %s got %0h expected %0h", name, actual, expected);
            err_cnt++;
        end
    endtask

    // Control register from the row fields with all function enables on
    function automatic logic [`FI_REG_W-1:0] control_word(input vec_t v);
        logic [`FI_REG_W-1:0] w;
        w = '0;
        w[`FI_BIT_EN] = 1'b1;
        w[`FI_TEST_LSB +: 4] = v.test;
        w[`FI_FUNC_LSB +: 4] = v.func;
        w[`FI_CRRESP_LSB +: `FI_CRRESP_W] = v.crresp;
        w[`FI_BIT_ACFLT] = v.acflt;
        w[`FI_BIT_ADDRFLT] = v.addrflt;
        w[`FI_BIT_OSH_EN] = 1'b1;
        w[`FI_BIT_CON_EN] = 1'b1;
        w[`FI_BIT_PDT_EN] = 1'b1;
        return w;
    endfunction

    // ------------------------------
    // One table row, trigger to reply
    // ------------------------------
    task automatic run_row(input int r);
        vec_t                    v;
        int                      cyc;
        int                      cr_cycles;
        int                      cr_lat;
        int                      cd_lat;
        int                      beats;
        int                      hold_cd;
        logic [`FI_CRRESP_W-1:0] cr_code;
        logic                    cr_prev;
        logic                    stalled;
        logic                    done;
        logic [`FI_DATA_W-1:0]   held_data;
        v = vec_tab[r];
        hold_cd = v.cd_hold;
        if (v.cd_rand)
            hold_cd = hold_cd + ($random(seed) & 7);
        @(negedge ace_aclk);
        i_control_reg      = control_word(v);
        i_delay_reg        = {28'h0, v.delay};
        i_acsnoop_snapshot = v.snoop;
        i_acsnoop_reg      = {28'h0, v.snoop_reg};
        i_acaddr_snapshot  = {12'hA5C, v.addr};
        i_base_addr_reg    = v.base;
        i_addr_size_reg    = v.size;
        i_crready          = 1'b1;
        i_cdready          = 1'b1;
        // Enable low for one idle cycle re-arms the one-shot
        if (v.idle_off)
        begin
            i_control_reg[`FI_BIT_EN] = 1'b0;
            @(negedge ace_aclk);
            check("o_end", o_end, 1'b0);
            i_control_reg[`FI_BIT_EN] = 1'b1;
        end
        check("o_busy", o_busy, 1'b0);
        i_trigger = 1'b1;
        i_crready = (v.cr_hold == 0);
        i_cdready = (hold_cd == 0);
        cyc = 0;
        cr_cycles = 0;
        cr_lat = 0;
        cd_lat = 0;
        cr_code = '0;
        beats = 0;
        stalled = 1'b0;
        held_data = '0;
        done = 1'b0;
        while (!done)
        begin
            cr_prev = i_crready;
            @(negedge ace_aclk);
            cyc++;
            i_trigger = 1'b0;
            if (!cr_prev)
            begin
                check("o_crvalid", o_crvalid, 1'b0);
                check("o_busy", o_busy, 1'b1);
            end
            if (o_crvalid)
            begin
                if (cr_cycles == 0)
                begin
                    cr_code = o_crresp;
                    cr_lat  = cyc;
                end
                cr_cycles++;
            end
            if (o_cdvalid && cd_lat == 0)
                cd_lat = cyc;
            if (stalled && o_cdvalid)
                check("o_cddata", o_cddata, held_data);
            i_crready = (cyc >= v.cr_hold);
            i_cdready = (cyc >= hold_cd);
            stalled   = o_cdvalid && !i_cdready;
            held_data = o_cddata;
            // Beat taken at the next rising edge
            if (o_cdvalid && i_cdready)
            begin
                if (v.exp_beats == `FI_BEATS && beats < `FI_BEATS)
                begin
                    check("o_cddata", o_cddata, i_cache_line[beats * `FI_DATA_W +: `FI_DATA_W]);
                    check("o_cdlast", o_cdlast, beats == `FI_BEATS - 1);
                end
                else
                begin
                    // Single fuzz beat comes with CR valid and last
                    check("o_crvalid", o_crvalid, 1'b1);
                    check("o_cdlast", o_cdlast, 1'b1);
                end
                beats++;
            end
            if (o_reply)
            begin
                done = 1'b1;
                check("o_end", o_end, v.exp_end);
            end
        end
        check("o_crvalid cycles", cr_cycles, 1);
        check("o_crresp", cr_code, v.exp_code);
        check("cd beats", beats, v.exp_beats);
        // Held back CR valid trails the early CD valid by the delay
        if (v.exp_min != 0 && (cd_lat == 0 || cr_lat - cd_lat < v.exp_min))
        begin
            $display("Row %0d did not hold CR valid back %0d cycles behind CD valid",
                     r, v.exp_min);
            err_cnt++;
        end
    endtask

    initial
    begin
        ace_aclk           = 1'b0;
        ace_aresetn        = 1'b0;
        i_trigger          = 1'b0;
        i_acaddr_snapshot  = '0;
        i_acsnoop_snapshot = '0;
        i_control_reg      = '0;
        i_delay_reg        = '0;
        i_acsnoop_reg      = '0;
        i_base_addr_reg    = '0;
        i_addr_size_reg    = '0;
        i_crready          = 1'b1;
        i_cdready          = 1'b1;
        for (int w = 0; w < `FI_LINE_W / 32; w++)
            i_cache_line[w * 32 +: 32] = $random(seed);

        repeat (2) @(negedge ace_aclk);
        ace_aresetn = 1'b1;

        // Quiet outputs out of reset
        check("o_crvalid", o_crvalid, 1'b0);
        check("o_cdvalid", o_cdvalid, 1'b0);
        check("o_cdlast", o_cdlast, 1'b0);
        check("o_reply", o_reply, 1'b0);
        check("o_end", o_end, 1'b0);
        check("o_busy", o_busy, 1'b0);
        check("o_crresp", o_crresp, '0);
        check("o_cddata", o_cddata, '0);

        for (int r = 0; r < NUM_VEC; r++)
            run_row(r);

        $display("%0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+verilog
+incdir+bench
verilog/snoop_fi_pkg.sv
verilog/snoop_ctrl_if.sv
verilog/snoop_resp_if.sv
verilog/snoop_ctrl_decode.sv
verilog/snoop_fault_fsm.sv
verilog/snoop_resp_driver.sv
verilog/snoop_fault_top.sv
bench/tb_snoop_fault.sv
